// ==== sources.f ====
source/sys_io_pkg.sv
source/hps_io_if.sv
source/button_debounce.sv
source/hps_gp_bridge.sv
source/cfg_decoder.sv
source/reset_request.sv
source/sys_io_top.sv
tb/tb_clock.sv
tb/sys_io_checker.sv
tb/sys_io_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -Wno-fatal --top-module sys_io_tb \
		-f sources.f -o sim_sys_io \
	&& ./obj_dir/sim_sys_io \
	|| { echo "Simulation build or run failed"; exit 1; }

// ==== tb/sys_io_tb.sv ====
// Directed testbench for the HPS I/O block, built and run by run_sim.sh
`default_nettype none
`timescale 1ns/1ps

module sys_io_tb;

	localparam int DEBOUNCE_DIV = 4;
	localparam int TICK_CYCLES  = DEBOUNCE_DIV + 1;
	// Two button holds of 12 ticks plus an allowance of 880 cycles for the channel tests
	localparam int TEST_CYCLES     = 24 * TICK_CYCLES + 880;
	localparam int WATCHDOG_CYCLES = 20 * TEST_CYCLES;

	logic                 FPGA_CLK2_50;
	logic                 resetd;
	sys_io_pkg::gp_word_t gp_out;
	sys_io_pkg::gp_word_t gp_in;
	logic                 btn_user_n;
	logic                 btn_osd_n;
	logic [1:0]           key;
	logic                 io_wait;
	sys_io_pkg::io_data_t io_dout;
	logic                 led_user_req;
	logic [1:0]           led_power_req;
	logic [1:0]           led_disk_req;
	sys_io_pkg::io_data_t io_din;
	logic                 io_strobe;
	logic                 io_osd;
	logic                 io_fpga;
	sys_io_pkg::io_data_t cfg;
	logic                 cfg_ready;
	logic                 reset_req;
	wire                  led_power;
	wire                  led_hdd;
	wire                  led_user;
	logic [7:0]           led;

	// Board pull-ups so a released pin reads high
	pullup (led_power);
	pullup (led_hdd);
	pullup (led_user);

	tb_clock #(.PERIOD_NS(8.0)) u_clock (.clk(FPGA_CLK2_50));

	sys_io_top #(.DEBOUNCE_DIV(DEBOUNCE_DIV), .CORE_TYPE(8'hA5)) DUT (
		.FPGA_CLK2_50 (FPGA_CLK2_50), .resetd (resetd), .gp_out (gp_out), .gp_in (gp_in),
		.btn_user_n (btn_user_n), .btn_osd_n (btn_osd_n), .key (key), .io_wait (io_wait),
		.io_dout (io_dout), .led_user_req (led_user_req), .led_power_req (led_power_req),
		.led_disk_req (led_disk_req), .io_din (io_din), .io_strobe (io_strobe),
		.io_osd (io_osd), .io_fpga (io_fpga), .cfg (cfg), .cfg_ready (cfg_ready),
		.reset_req (reset_req), .led_power (led_power), .led_hdd (led_hdd),
		.led_user (led_user), .led (led)
	);

	// ============================================================
	// Helpers
	// ============================================================
	task automatic stop_with_failure(input string reason);
		$display("Result: FAILED");
		$fatal(1, "%s", reason);
	endtask

	task automatic check_value(input string test_name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("FAILED %s: expected %h, actual %h", test_name, expected, actual);
			stop_with_failure({"wrong value in ", test_name});
		end
	endtask

	// Inputs change 1 ns after the edge
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge FPGA_CLK2_50);
		#1;
	endtask

	// One io_clk toggle per word with the ack back after 4 cycles
	task automatic send_word(input sys_io_pkg::io_data_t word);
		gp_out[15:0] = word;
		gp_out[17]   = ~gp_out[17];
		wait_cycles(5);
	endtask

	// ============================================================
	// Tests
	// ============================================================
	task automatic after_reset();
		check_value("after_reset cfg_ready", 32'd0, 32'(cfg_ready));
		check_value("after_reset reset_req", 32'd0, 32'(reset_req));
		check_value("after_reset cfg", 32'd0, 32'(cfg));
		check_value("after_reset magic", 32'h5CA623A5, gp_in);
	endtask

	task automatic status_packing();
		sys_io_pkg::io_data_t dout;
		dout       = 16'($urandom);
		io_dout    = dout;
		gp_out[31] = 1'b1;
		wait_cycles(1);
		// Buttons, version, wide and ack all zero here
		check_value("status_packing", {16'h0000, dout}, gp_in);
	endtask

	task automatic strobe_and_ack();
		logic ack_exp;
		logic ack_old;
		repeat (2) begin
			gp_out[17] = ~gp_out[17];
			ack_exp    = gp_out[17];
			wait_cycles(2);
			check_value("strobe_and_ack strobe high", 32'd1, 32'(io_strobe));
			wait_cycles(1);
			check_value("strobe_and_ack strobe low", 32'd0, 32'(io_strobe));
			check_value("strobe_and_ack ack early", 32'(!ack_exp), 32'(gp_in[16]));
			wait_cycles(1);
			check_value("strobe_and_ack ack", 32'(ack_exp), 32'(gp_in[16]));
		end
		// rack still moves on the strobe while io_ack freezes
		ack_old    = gp_in[16];
		io_wait    = 1'b1;
		gp_out[17] = ~gp_out[17];
		wait_cycles(4);
		check_value("strobe_and_ack hold", 32'(ack_old), 32'(gp_in[16]));
		wait_cycles(6);
		check_value("strobe_and_ack hold long", 32'(ack_old), 32'(gp_in[16]));
		io_wait = 1'b0;
		wait_cycles(1);
		check_value("strobe_and_ack release", 32'(gp_out[17]), 32'(gp_in[16]));
	endtask

	task automatic channel_fields();
		sys_io_pkg::io_data_t word;
		word          = 16'($urandom % 65535) + 16'd1;
		gp_out[15:0]  = word;
		gp_out[19:18] = 2'b01;
		wait_cycles(1);
		check_value("channel_fields din early", 32'd0, 32'(io_din));
		wait_cycles(1);
		check_value("channel_fields din", 32'(word), 32'(io_din));
		check_value("channel_fields fpga on", 32'd1, 32'(io_fpga));
		check_value("channel_fields osd off", 32'd0, 32'(io_osd));
		gp_out[19:18] = 2'b10;
		wait_cycles(2);
		check_value("channel_fields fpga off", 32'd0, 32'(io_fpga));
		check_value("channel_fields osd on", 32'd1, 32'(io_osd));
		gp_out[19:18] = 2'b00;
		wait_cycles(2);
	endtask

	task automatic config_load();
		sys_io_pkg::io_data_t data;
		sys_io_pkg::cmd_t     other_cmd;
		data       = 16'($urandom);
		gp_out[20] = 1'b1;
		wait_cycles(3);
		send_word(16'h0001);
		send_word(data);
		check_value("config_load cfg", 32'(data), 32'(cfg));
		check_value("config_load cfg_ready", 32'd1, 32'(cfg_ready));
		// New transfer with some other command
		gp_out[20] = 1'b0;
		wait_cycles(3);
		gp_out[20] = 1'b1;
		wait_cycles(3);
		other_cmd = 8'd2 + 8'($urandom % 200);
		send_word({8'h00, other_cmd});
		send_word(~data);
		check_value("config_load other command", 32'(data), 32'(cfg));
		gp_out[20] = 1'b0;
		wait_cycles(3);
	endtask

	task automatic reset_guard();
		gp_out[31:30] = 2'd0;
		wait_cycles(4);
		check_value("reset_guard idle", 32'd0, 32'(reset_req));
		gp_out[31:30] = 2'd1;
		wait_cycles(4);
		check_value("reset_guard set", 32'd1, 32'(reset_req));
		gp_out[31:30] = 2'd3;
		wait_cycles(4);
		gp_out[31:30] = 2'd2;
		wait_cycles(4);
		check_value("reset_guard 3 then 2", 32'd1, 32'(reset_req));
		gp_out[31:30] = 2'd0;
		wait_cycles(4);
		gp_out[31:30] = 2'd2;
		wait_cycles(4);
		check_value("reset_guard 0 then 2", 32'd0, 32'(reset_req));
	endtask

	task automatic buttons_and_leds();
		logic       p_on;
		logic       d_on;
		logic       u_on;
		logic [7:0] led_exp;
		btn_user_n = 1'b0;
		wait_cycles(12 * TICK_CYCLES);
		check_value("buttons_and_leds user pressed", 32'd1, 32'(gp_in[30]));
		check_value("buttons_and_leds osd idle", 32'd0, 32'(gp_in[29]));
		btn_user_n = 1'b1;
		wait_cycles(12 * TICK_CYCLES);
		check_value("buttons_and_leds user released", 32'd0, 32'(gp_in[30]));
		repeat (8) begin
			led_user_req  = 1'($urandom);
			led_power_req = 2'($urandom);
			led_disk_req  = 2'($urandom);
			gp_out[29]    = 1'($urandom);
			#1;
			p_on = (led_power_req == 2'b10);
			d_on = (led_disk_req == 2'b10) || (led_disk_req == 2'b01)
				|| (led_disk_req == 2'b00 && gp_out[29]);
			u_on = led_user_req;
			led_exp    = 8'h00;
			led_exp[4] = p_on;
			led_exp[2] = d_on;
			led_exp[0] = u_on;
			check_value("buttons_and_leds power pin", 32'(p_on), 32'(led_power));
			check_value("buttons_and_leds disk pin", 32'(d_on), 32'(led_hdd));
			check_value("buttons_and_leds user pin", 32'(u_on), 32'(led_user));
			check_value("buttons_and_leds led bus", 32'(led_exp), 32'(led));
			wait_cycles(1);
		end
	endtask

	// ============================================================
	// Main sequence and watchdog
	// ============================================================
	initial begin
		void'($urandom(19374));
		resetd        = 1'b1;
		gp_out        = '0;
		btn_user_n    = 1'b1;
		btn_osd_n     = 1'b1;
		key           = 2'b11;
		io_wait       = 1'b0;
		io_dout       = '0;
		led_user_req  = 1'b0;
		led_power_req = 2'b00;
		led_disk_req  = 2'b00;
		wait_cycles(10);
		resetd = 1'b0;
		after_reset();
		status_packing();
		strobe_and_ack();
		channel_fields();
		config_load();
		reset_guard();
		buttons_and_leds();
		$display("Result: PASSED");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge FPGA_CLK2_50);
		stop_with_failure($sformatf("Timeout, no result after %0d clock cycles",
			WATCHDOG_CYCLES));
	end

endmodule

`default_nettype wire

// ==== tb/sys_io_checker.sv ====
// Concurrent assertions on ack hold, reset request and reset state, bound into the bridge and reset latch
`default_nettype none
`timescale 1ns/1ps

module sys_io_checker (
	input logic                  FPGA_CLK2_50,
	input logic                  resetd,
	input logic                  io_wait,
	input logic                  io_strobe,
	input logic                  io_ack,
	input sys_io_pkg::rst_code_t rst_code_d,
	input logic                  reset_req
);

	// Core waiting and no new strobe, so the ack stays frozen
	ack_hold: assert property (@(posedge FPGA_CLK2_50) disable iff (resetd)
		(io_wait && !io_strobe) |=> $stable(io_ack))
		else $error("io_ack changed while io_wait was high and io_strobe low");

	// Only the set code may raise the request
	req_rise: assert property (@(posedge FPGA_CLK2_50) disable iff (resetd)
		$rose(reset_req) |-> (rst_code_d == 2'd1))
		else $error("reset_req rose without reset code 1");

	reset_state: assert property (@(posedge FPGA_CLK2_50)
		resetd |=> (!reset_req && !io_ack))
		else $error("reset_req or io_ack not cleared by resetd");

endmodule

// Bridge instance sees the ack side, the reset latch its own request
bind hps_gp_bridge sys_io_checker u_checker (
	.FPGA_CLK2_50 (FPGA_CLK2_50),
	.resetd       (resetd),
	.io_wait      (io_wait),
	.io_strobe    (io.io_strobe),
	.io_ack       (io_ack),
	.rst_code_d   (2'd0),
	.reset_req    (1'b0)
);

bind reset_request sys_io_checker u_checker (
	.FPGA_CLK2_50 (FPGA_CLK2_50),
	.resetd       (resetd),
	.io_wait      (1'b0),
	.io_strobe    (1'b0),
	.io_ack       (1'b0),
	.rst_code_d   (rst_code_d),
	.reset_req    (reset_req)
);

`default_nettype wire

// ==== tb/tb_clock.sv ====
// Free-running testbench clock for the HPS I/O block simulation
`default_nettype none
`timescale 1ns/1ps

module tb_clock #(
	parameter real PERIOD_NS = 8.0
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2.0) clk = ~clk;
	end

endmodule

`default_nettype wire

// ==== source/sys_io_top.sv ====
// Top level of the HPS I/O block: buttons, HPS bridge, cfg decoder, reset guard, LED drive
`default_nettype none
`timescale 1ns/1ps

module sys_io_top #(
	parameter int         DEBOUNCE_DIV = 100000,
	parameter logic [7:0] CORE_TYPE    = 8'hA5
) (
	input  logic                 FPGA_CLK2_50,
	input  logic                 resetd,
	input  sys_io_pkg::gp_word_t gp_out,
	output sys_io_pkg::gp_word_t gp_in,
	input  logic                 btn_user_n,
	input  logic                 btn_osd_n,
	input  logic [1:0]           key,
	input  logic                 io_wait,
	input  sys_io_pkg::io_data_t io_dout,
	input  logic                 led_user_req,
	input  logic [1:0]           led_power_req,
	input  logic [1:0]           led_disk_req,
	output sys_io_pkg::io_data_t io_din,
	output logic                 io_strobe,
	output logic                 io_osd,
	output logic                 io_fpga,
	output sys_io_pkg::io_data_t cfg,
	output logic                 cfg_ready,
	output logic                 reset_req,
	output wire                  led_power,
	output wire                  led_hdd,
	output wire                  led_user,
	output logic [7:0]           led
);

	logic                  btn_user;
	logic                  btn_osd;
	sys_io_pkg::rst_code_t rst_code;
	logic                  power_on;
	logic                  disk_on;
	logic                  user_on;

	hps_io_if io_bus ();

	// ============================================================
	// Buttons, board and motherboard keys combined
	// ============================================================
	button_debounce #(.DEBOUNCE_DIV(DEBOUNCE_DIV)) u_deb_user (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.btn_n        (btn_user_n & key[1]),
		.pressed      (btn_user)
	);

	button_debounce #(.DEBOUNCE_DIV(DEBOUNCE_DIV)) u_deb_osd (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.btn_n        (btn_osd_n & key[0]),
		.pressed      (btn_osd)
	);

	// ============================================================
	// HPS side
	// ============================================================
	hps_gp_bridge #(.CORE_TYPE(CORE_TYPE)) u_bridge (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.gp_out       (gp_out),
		.gp_in        (gp_in),
		.io_wait      (io_wait),
		.io_dout      (io_dout),
		.btn_user     (btn_user),
		.btn_osd      (btn_osd),
		.rst_code     (rst_code),
		.io           (io_bus.bridge)
	);

	cfg_decoder u_cfg (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.io           (io_bus.cfg),
		.cfg          (cfg),
		.cfg_ready    (cfg_ready)
	);

	reset_request u_rst_req (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.rst_code     (rst_code),
		.reset_req    (reset_req)
	);

	// Channel outputs toward the core
	assign io_din    = io_bus.io_din;
	assign io_strobe = io_bus.io_strobe;
	assign io_osd    = io_bus.io_osd;
	assign io_fpga   = io_bus.io_fpga;

	// ============================================================
	// LEDs
	// ============================================================
	assign power_on = led_power_req[1] & ~led_power_req[0];
	// Bit 29 from the HPS also lights the disk LED in auto mode
	assign disk_on  = led_disk_req[1] ? ~led_disk_req[0] : (led_disk_req[0] | gp_out[29]);
	assign user_on  = led_user_req;

	// Open-drain pins, released when lit
	assign led_power = power_on ? 1'bz : 1'b0;
	assign led_hdd   = disk_on ? 1'bz : 1'b0;
	assign led_user  = user_on ? 1'bz : 1'b0;

	assign led = {3'b000, power_on, 1'b0, disk_on, 1'b0, user_on};

endmodule

`default_nettype wire

// ==== source/reset_request.sv ====
// Guarded core reset latch driven by the reset code sequence on gp_out[31:30]
`default_nettype none
`timescale 1ns/1ps

module reset_request (
	input  logic                  FPGA_CLK2_50,
	input  logic                  resetd,
	input  sys_io_pkg::rst_code_t rst_code,
	output logic                  reset_req
);

	sys_io_pkg::rst_code_t rst_code_d;

	// Previous code, so clear needs the 0 then 2 sequence
	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			rst_code_d <= '0;
		end else begin
			rst_code_d <= rst_code;
		end
	end

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			reset_req <= 1'b0;
		end else if (rst_code == 2'd1) begin
			reset_req <= 1'b1;
		end else if (rst_code == 2'd2 && rst_code_d == 2'd0) begin
			reset_req <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== source/cfg_decoder.sv ====
// Command decoder on the uio channel that loads the cfg word for command 1
`default_nettype none
`timescale 1ns/1ps

module cfg_decoder (
	input  logic                 FPGA_CLK2_50,
	input  logic                 resetd,
	hps_io_if.cfg                io,
	output sys_io_pkg::io_data_t cfg,
	output logic                 cfg_ready
);

	sys_io_pkg::cmd_t cmd;
	logic             has_cmd;
	logic             old_strobe;
	logic             strobe_rise;

	assign strobe_rise = io.io_strobe & ~old_strobe;

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			old_strobe <= 1'b0;
			has_cmd    <= 1'b0;
			cfg        <= '0;
			cfg_ready  <= 1'b0;
		end else begin
			old_strobe <= io.io_strobe;
			// uio low ends the transfer
			if (!io.io_uio) begin
				has_cmd <= 1'b0;
			end else if (strobe_rise) begin
				if (!has_cmd) begin
					has_cmd <= 1'b1;
				end else if (cmd == sys_io_pkg::CFG_CMD) begin
					cfg       <= io.io_din;
					cfg_ready <= 1'b1;
				end
			end
		end
	end

	// First word of a transfer is the command
	always_ff @(posedge FPGA_CLK2_50) begin
		if (io.io_uio && strobe_rise && !has_cmd) begin
			cmd <= io.io_din[7:0];
		end
	end

endmodule

`default_nettype wire

// ==== source/hps_gp_bridge.sv ====
// HPS general-purpose port bridge: synchronizer, I/O strobe and ack, gp_in status packing
`default_nettype none
`timescale 1ns/1ps

module hps_gp_bridge #(
	parameter logic [7:0] CORE_TYPE = 8'hA5
) (
	input  logic                  FPGA_CLK2_50,
	input  logic                  resetd,
	input  sys_io_pkg::gp_word_t  gp_out,
	output sys_io_pkg::gp_word_t  gp_in,
	input  logic                  io_wait,
	input  sys_io_pkg::io_data_t  io_dout,
	input  logic                  btn_user,
	input  logic                  btn_osd,
	output sys_io_pkg::rst_code_t rst_code,
	hps_io_if.bridge              io
);

	// Standard I/O protocol, narrow bus
	localparam logic [1:0] IO_VER  = 2'd0;
	localparam logic       IO_WIDE = 1'b0;

	sys_io_pkg::gp_word_t gp_outd;
	sys_io_pkg::gp_word_t gp_outr;
	sys_io_pkg::gp_word_t status_word;
	logic                 io_clk;
	logic                 rack;
	logic                 io_ack;

	// ============================================================
	// Two-stage synchronizer
	// ============================================================
	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			gp_outd <= '0;
			gp_outr <= '0;
		end else begin
			gp_outd <= gp_out;
			gp_outr <= gp_outd;
		end
	end

	// Field split of the synchronized word
	assign io.io_din  = gp_outr[15:0];
	assign io_clk     = gp_outr[17];
	assign io.io_fpga = gp_outr[18];
	assign io.io_osd  = gp_outr[19];
	assign io.io_uio  = gp_outr[20];
	assign rst_code   = gp_outr[31:30];

	// ============================================================
	// Toggle strobe and acknowledge
	// ============================================================
	assign io.io_strobe = io_clk ^ rack;

	// Ack frozen while the core waits, unless a new strobe is pending
	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			rack   <= 1'b0;
			io_ack <= 1'b0;
		end else if (!io_wait || io.io_strobe) begin
			rack   <= io_clk;
			io_ack <= rack;
		end
	end

	// Bit 31 low tells the HPS that the FPGA is configured
	assign status_word = {1'b0, btn_user, btn_osd, 9'd0, IO_VER, IO_WIDE, io_ack, io_dout};

	// Magic word until the processor sets bit 31
	assign gp_in = gp_out[31] ? status_word : {sys_io_pkg::MAGIC_PREFIX, CORE_TYPE};

endmodule

`default_nettype wire

// ==== source/button_debounce.sv ====
// Debouncer for one active-low board button, instantiated once per button in the top level
`default_nettype none
`timescale 1ns/1ps

module button_debounce #(
	parameter int DEBOUNCE_DIV = 100000
) (
	input  logic FPGA_CLK2_50,
	input  logic resetd,
	input  logic btn_n,
	output logic pressed
);

	localparam int DIV_W = $clog2(DEBOUNCE_DIV + 1);

	logic [DIV_W-1:0] div_cnt;
	logic             tick;
	logic [7:0]       history;

	// Tick once every DEBOUNCE_DIV+1 clocks
	assign tick = (div_cnt == '0);

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			div_cnt <= '0;
		end else if (div_cnt == DIV_W'(DEBOUNCE_DIV)) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// Sample history, output moves only on a full run of equal samples
	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			history <= '0;
			pressed <= 1'b0;
		end else if (tick) begin
			history <= {history[6:0], ~btn_n};
			if (&history) begin
				pressed <= 1'b1;
			end
			if (history == 8'h00) begin
				pressed <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/hps_io_if.sv ====
// Synchronized I/O channel bundle between the HPS bridge and its consumers
`default_nettype none
`timescale 1ns/1ps

interface hps_io_if;

	// Data word and strobe of the I/O channel
	sys_io_pkg::io_data_t io_din;
	logic io_strobe;

	// Target selects
	logic io_uio;
	logic io_osd;
	logic io_fpga;

	// Bridge side drives everything
	modport bridge (output io_din, output io_strobe, output io_uio, output io_osd,
		output io_fpga);

	// Config decoder side
	modport cfg (input io_din, input io_strobe, input io_uio, input io_osd,
		input io_fpga);

endinterface

`default_nettype wire

// ==== source/sys_io_pkg.sv ====
// Shared widths, word types and protocol constants for the HPS I/O block; referenced by scope
`default_nettype none

package sys_io_pkg;

	// ============================================================
	// Word types
	// ============================================================

	// Processor general-purpose word, both directions
	typedef logic [31:0] gp_word_t;

	// I/O channel data and the cfg word
	typedef logic [15:0] io_data_t;

	// Command byte sent at the start of a uio transfer
	typedef logic [7:0] cmd_t;

	// Reset control code from gp_out[31:30]
	typedef logic [1:0] rst_code_t;

	// ============================================================
	// Constants
	// ============================================================

	// Upper part of the magic word, the core type fills the low byte
	localparam logic [23:0] MAGIC_PREFIX = 24'h5CA623;

	// Command that loads the cfg word
	localparam cmd_t CFG_CMD = 8'd1;

endpackage

`default_nettype wire
